/* src/decode_pkg.sv */
package decode_pkg;

    // core shape.
    localparam int LANES       = 2;
    localparam int QUEUE_DEPTH = 8;
    localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
    localparam int QCNT_W      = $clog2(QUEUE_DEPTH + 1);

    // primary opcodes of the supported subset.
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_JAL     = 6'h03;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    // funct codes inside the SPECIAL group.
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_JR   = 6'h08;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_OR   = 6'h25;

    // link register written by JAL.
    localparam logic [4:0] REG_RA = 5'd31;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] sa;
        logic [5:0] funct;
    } r_view_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imme;
    } i_view_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target;
    } j_view_t;

    // one instruction word seen through the three MIPS formats.
    typedef union packed {
        r_view_t r;
        i_view_t i;
        j_view_t j;
    } inst_t;

endpackage

/* src/fetch_slot_if.sv */
`timescale 1ns/1ps

interface fetch_slot_if;
    import decode_pkg::*;

    logic        valid;
    logic [31:0] pc;
    inst_t       inst;
    logic        fetch_err;
    // driven by the lane, high when the slot was not taken this cycle.
    logic        stall;

    modport queue (output valid, pc, inst, fetch_err, input stall);
    modport lane (input valid, pc, inst, fetch_err, output stall);

endinterface

/* src/id_bus_if.sv */
`timescale 1ns/1ps

interface id_bus_if;

    logic        valid;
    logic [31:0] pc;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic        w_reg_ena;
    logic [4:0]  w_reg_dst;
    // I-type immediate, or the low half of the jump target.
    logic [15:0] imme;
    logic        is_branch;
    logic        is_ls;
    logic        is_ri;
    logic        fetch_err;

    modport lane (
        output valid, pc,
        output rs, rt,
        output w_reg_ena, w_reg_dst,
        output imme,
        output is_branch, is_ls, is_ri,
        output fetch_err
    );

    modport issue (
        input valid, pc,
        input rs, rt,
        input w_reg_ena, w_reg_dst,
        input imme,
        input is_branch, is_ls, is_ri,
        input fetch_err
    );

endinterface

/* src/fetch_queue.sv */
`timescale 1ns/1ps

module fetch_queue (
    input  logic        clk,
    input  logic        reset_i,
    input  logic        flush_i,
    input  logic        fetch_valid_i,
    input  logic [31:0] fetch_pc_i,
    input  logic [31:0] fetch_inst_i,
    input  logic        fetch_err_i,
    output logic        fetch_ready_o,
    fetch_slot_if.queue slot_o [decode_pkg::LANES]
);
    import decode_pkg::*;

    logic [31:0]       pc_q   [QUEUE_DEPTH];
    inst_t             inst_q [QUEUE_DEPTH];
    logic              err_q  [QUEUE_DEPTH];
    logic [QPTR_W-1:0] rd_ptr;
    logic [QPTR_W-1:0] wr_ptr;
    logic [QCNT_W-1:0] count;
    logic [QCNT_W-1:0] pop_cnt;
    logic              push;
    logic              stall;

    assign fetch_ready_o = (count != QCNT_W'(QUEUE_DEPTH));
    assign push          = fetch_valid_i && fetch_ready_o;
    assign stall         = slot_o[0].stall | slot_o[1].stall;

    // both head entries leave together, or the single one when that is all there is.
    assign pop_cnt = stall ? '0 : ((count >= QCNT_W'(2)) ? QCNT_W'(2) : count);

    always_ff @(posedge clk) begin
        if (push) begin
            pc_q[wr_ptr]   <= fetch_pc_i;
            inst_q[wr_ptr] <= fetch_inst_i;
            err_q[wr_ptr]  <= fetch_err_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            rd_ptr <= rd_ptr + QPTR_W'(pop_cnt);
            count  <= count + QCNT_W'(push) - pop_cnt;
        end
    end

    for (genvar g = 0; g < LANES; g++) begin : g_slot
        logic [QPTR_W-1:0] idx;

        assign idx                 = rd_ptr + QPTR_W'(g);
        assign slot_o[g].valid     = (count > QCNT_W'(g));
        assign slot_o[g].pc        = pc_q[idx];
        assign slot_o[g].inst      = inst_q[idx];
        assign slot_o[g].fetch_err = err_q[idx];
    end

    // the write pointer leads the read pointer by count, and count never passes the depth.
    count_matches_ptrs: assert property (@(posedge clk) disable iff (reset_i)
        (count <= QCNT_W'(QUEUE_DEPTH)) && (wr_ptr == rd_ptr + QPTR_W'(count)));

endmodule

/* src/id_stage_reg.sv */
`timescale 1ns/1ps

module id_stage_reg (
    input  logic        clk,
    input  logic        reset_i,
    input  logic        flush_i,
    input  logic        stall_i,
    input  logic        d_valid_i,
    input  logic [31:0] d_pc_i,
    input  logic [4:0]  d_rs_i,
    input  logic [4:0]  d_rt_i,
    input  logic        d_w_reg_ena_i,
    input  logic [4:0]  d_w_reg_dst_i,
    input  logic [15:0] d_imme_i,
    input  logic        d_is_branch_i,
    input  logic        d_is_ls_i,
    input  logic        d_is_ri_i,
    input  logic        d_fetch_err_i,
    id_bus_if.lane      out_o
);

    // an empty slot clears the stage so no stale fields reach issue.
    always_ff @(posedge clk) begin
        if (reset_i || flush_i || (!d_valid_i && !stall_i)) begin
            out_o.valid     <= 1'b0;
            out_o.pc        <= 32'h0;
            out_o.rs        <= 5'h0;
            out_o.rt        <= 5'h0;
            out_o.w_reg_ena <= 1'b0;
            out_o.w_reg_dst <= 5'h0;
            out_o.imme      <= 16'h0;
            out_o.is_branch <= 1'b0;
            out_o.is_ls     <= 1'b0;
            out_o.is_ri     <= 1'b0;
            out_o.fetch_err <= 1'b0;
        end else if (!stall_i) begin
            out_o.valid     <= d_valid_i;
            out_o.pc        <= d_pc_i;
            out_o.rs        <= d_rs_i;
            out_o.rt        <= d_rt_i;
            out_o.w_reg_ena <= d_w_reg_ena_i;
            out_o.w_reg_dst <= d_w_reg_dst_i;
            out_o.imme      <= d_imme_i;
            out_o.is_branch <= d_is_branch_i;
            out_o.is_ls     <= d_is_ls_i;
            out_o.is_ri     <= d_is_ri_i;
            out_o.fetch_err <= d_fetch_err_i;
        end
    end

endmodule

/* src/decode_lane.sv */
`timescale 1ns/1ps

module decode_lane (
    input  logic       clk,
    input  logic       reset_i,
    input  logic       flush_i,
    input  logic       stall_i,
    fetch_slot_if.lane slot_i,
    id_bus_if.lane     out_o
);
    import decode_pkg::*;

    inst_t       inst;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic        w_reg_ena;
    logic [4:0]  w_reg_dst;
    logic [15:0] imme;
    logic        is_branch;
    logic        is_ls;
    logic        is_ri;

    assign inst = slot_i.inst;

    // the queue pops only on cycles where the lanes load.
    assign slot_i.stall = stall_i;

    always_comb begin
        rs        = inst.i.rs;
        rt        = inst.i.rt;
        w_reg_ena = 1'b0;
        w_reg_dst = 5'd0;
        imme      = inst.i.imme;
        is_branch = 1'b0;
        is_ls     = 1'b0;
        is_ri     = 1'b0;
        case (inst.r.opcode)
            OP_SPECIAL: begin
                case (inst.r.funct)
                    FN_ADDU, FN_SUBU, FN_OR, FN_SLL: begin
                        w_reg_ena = 1'b1;
                        w_reg_dst = inst.r.rd;
                    end
                    FN_JR: is_branch = 1'b1;
                    default: is_ri = 1'b1;
                endcase
            end
            OP_ADDIU, OP_ORI, OP_LUI: begin
                w_reg_ena = 1'b1;
                w_reg_dst = inst.i.rt;
            end
            OP_LW: begin
                w_reg_ena = 1'b1;
                w_reg_dst = inst.i.rt;
                is_ls     = 1'b1;
            end
            OP_SW: is_ls = 1'b1;
            OP_BEQ, OP_BNE: is_branch = 1'b1;
            OP_J, OP_JAL: begin
                // register fields overlap the target here, so they read nothing.
                rs        = 5'd0;
                rt        = 5'd0;
                imme      = inst.j.target[15:0];
                is_branch = 1'b1;
                w_reg_ena = (inst.j.opcode == OP_JAL);
                w_reg_dst = (inst.j.opcode == OP_JAL) ? REG_RA : 5'd0;
            end
            default: is_ri = 1'b1;
        endcase
        if (is_ri) begin
            rs = 5'd0;
            rt = 5'd0;
        end
    end

    id_stage_reg i_id_stage_reg (
        .clk           (clk),
        .reset_i       (reset_i),
        .flush_i       (flush_i),
        .stall_i       (stall_i),
        .d_valid_i     (slot_i.valid),
        .d_pc_i        (slot_i.pc),
        .d_rs_i        (rs),
        .d_rt_i        (rt),
        .d_w_reg_ena_i (w_reg_ena),
        .d_w_reg_dst_i (w_reg_dst),
        .d_imme_i      (imme),
        .d_is_branch_i (is_branch),
        .d_is_ls_i     (is_ls),
        .d_is_ri_i     (is_ri),
        .d_fetch_err_i (slot_i.fetch_err),
        .out_o         (out_o)
    );

endmodule

/* src/issue_pair.sv */
`timescale 1ns/1ps

module issue_pair (
    input  logic        clk,
    input  logic        reset_i,
    input  logic        flush_i,
    input  logic        exec_ready_i,
    id_bus_if.issue     in_i [decode_pkg::LANES],
    output logic        stall_o,
    output logic        iss0_valid_o,
    output logic [31:0] iss0_pc_o,
    output logic [4:0]  iss0_rs_o,
    output logic [4:0]  iss0_rt_o,
    output logic        iss0_w_reg_ena_o,
    output logic [4:0]  iss0_w_reg_dst_o,
    output logic [15:0] iss0_imme_o,
    output logic        iss0_is_branch_o,
    output logic        iss0_is_ls_o,
    output logic        iss0_is_ri_o,
    output logic        iss0_fetch_err_o,
    output logic        iss1_valid_o,
    output logic [31:0] iss1_pc_o,
    output logic [4:0]  iss1_rs_o,
    output logic [4:0]  iss1_rt_o,
    output logic        iss1_w_reg_ena_o,
    output logic [4:0]  iss1_w_reg_dst_o,
    output logic [15:0] iss1_imme_o,
    output logic        iss1_is_branch_o,
    output logic        iss1_is_ls_o,
    output logic        iss1_is_ri_o,
    output logic        iss1_fetch_err_o
);

    logic slot0_done;
    logic raw_hazard;
    logic may_pair;
    logic split;

    assign raw_hazard = in_i[0].w_reg_ena && (in_i[0].w_reg_dst != 5'd0) &&
                        ((in_i[0].w_reg_dst == in_i[1].rs) ||
                         (in_i[0].w_reg_dst == in_i[1].rt));
    assign may_pair   = !raw_hazard && !(in_i[0].is_ls && in_i[1].is_ls) &&
                        !in_i[0].is_branch;

    // the older instruction goes alone and the younger one waits a cycle.
    assign split   = !slot0_done && in_i[0].valid && in_i[1].valid && !may_pair;
    assign stall_o = !exec_ready_i || split;

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            iss0_valid_o <= 1'b0;
            iss1_valid_o <= 1'b0;
            slot0_done   <= 1'b0;
        end else if (exec_ready_i) begin
            iss0_valid_o <= slot0_done ? in_i[1].valid : in_i[0].valid;
            iss1_valid_o <= !slot0_done && in_i[0].valid && in_i[1].valid && may_pair;
            slot0_done   <= split;
        end
    end

    // once lane 0 has gone out, lane 1 moves to output slot 0.
    always_ff @(posedge clk) begin
        if (exec_ready_i) begin
            iss0_pc_o        <= slot0_done ? in_i[1].pc        : in_i[0].pc;
            iss0_rs_o        <= slot0_done ? in_i[1].rs        : in_i[0].rs;
            iss0_rt_o        <= slot0_done ? in_i[1].rt        : in_i[0].rt;
            iss0_w_reg_ena_o <= slot0_done ? in_i[1].w_reg_ena : in_i[0].w_reg_ena;
            iss0_w_reg_dst_o <= slot0_done ? in_i[1].w_reg_dst : in_i[0].w_reg_dst;
            iss0_imme_o      <= slot0_done ? in_i[1].imme      : in_i[0].imme;
            iss0_is_branch_o <= slot0_done ? in_i[1].is_branch : in_i[0].is_branch;
            iss0_is_ls_o     <= slot0_done ? in_i[1].is_ls     : in_i[0].is_ls;
            iss0_is_ri_o     <= slot0_done ? in_i[1].is_ri     : in_i[0].is_ri;
            iss0_fetch_err_o <= slot0_done ? in_i[1].fetch_err : in_i[0].fetch_err;
            iss1_pc_o        <= in_i[1].pc;
            iss1_rs_o        <= in_i[1].rs;
            iss1_rt_o        <= in_i[1].rt;
            iss1_w_reg_ena_o <= in_i[1].w_reg_ena;
            iss1_w_reg_dst_o <= in_i[1].w_reg_dst;
            iss1_imme_o      <= in_i[1].imme;
            iss1_is_branch_o <= in_i[1].is_branch;
            iss1_is_ls_o     <= in_i[1].is_ls;
            iss1_is_ri_o     <= in_i[1].is_ri;
            iss1_fetch_err_o <= in_i[1].fetch_err;
        end
    end

    slot1_needs_slot0: assert property (@(posedge clk) disable iff (reset_i)
        iss1_valid_o |-> iss0_valid_o);

    pair_obeys_rule: assert property (@(posedge clk) disable iff (reset_i)
        iss1_valid_o |-> (!iss0_is_branch_o && !(iss0_is_ls_o && iss1_is_ls_o) &&
            !(iss0_w_reg_ena_o && (iss0_w_reg_dst_o != 5'd0) &&
              ((iss0_w_reg_dst_o == iss1_rs_o) || (iss0_w_reg_dst_o == iss1_rt_o)))));

endmodule

/* src/decode_issue_top.sv */
`timescale 1ns/1ps

module decode_issue_top (
    input  logic        clk,
    input  logic        reset_i,
    input  logic        flush_i,
    input  logic        fetch_valid_i,
    input  logic [31:0] fetch_pc_i,
    input  logic [31:0] fetch_inst_i,
    input  logic        fetch_err_i,
    output logic        fetch_ready_o,
    input  logic        exec_ready_i,
    output logic        iss0_valid_o,
    output logic [31:0] iss0_pc_o,
    output logic [4:0]  iss0_rs_o,
    output logic [4:0]  iss0_rt_o,
    output logic        iss0_w_reg_ena_o,
    output logic [4:0]  iss0_w_reg_dst_o,
    output logic [15:0] iss0_imme_o,
    output logic        iss0_is_branch_o,
    output logic        iss0_is_ls_o,
    output logic        iss0_is_ri_o,
    output logic        iss0_fetch_err_o,
    output logic        iss1_valid_o,
    output logic [31:0] iss1_pc_o,
    output logic [4:0]  iss1_rs_o,
    output logic [4:0]  iss1_rt_o,
    output logic        iss1_w_reg_ena_o,
    output logic [4:0]  iss1_w_reg_dst_o,
    output logic [15:0] iss1_imme_o,
    output logic        iss1_is_branch_o,
    output logic        iss1_is_ls_o,
    output logic        iss1_is_ri_o,
    output logic        iss1_fetch_err_o
);
    import decode_pkg::*;

    logic stall;

    fetch_slot_if slot [LANES] ();
    id_bus_if     bus  [LANES] ();

    fetch_queue i_fetch_queue (
        .*,
        .slot_o (slot)
    );

    for (genvar g = 0; g < LANES; g++) begin : g_lane
        decode_lane i_decode_lane (
            .clk     (clk),
            .reset_i (reset_i),
            .flush_i (flush_i),
            .stall_i (stall),
            .slot_i  (slot[g]),
            .out_o   (bus[g])
        );
    end

    // one stall freezes both lanes and the queue head together.
    issue_pair i_issue_pair (
        .*,
        .in_i    (bus),
        .stall_o (stall)
    );

endmodule

/* tests/tb_decode_ref.svh */
`ifndef TB_DECODE_REF_SVH
`define TB_DECODE_REF_SVH

// expected fields of one issued instruction, in output port order.
typedef struct packed {
    logic [31:0] pc;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic        w_reg_ena;
    logic [4:0]  w_reg_dst;
    logic [15:0] imme;
    logic        is_branch;
    logic        is_ls;
    logic        is_ri;
    logic        fetch_err;
} dec_t;

function automatic dec_t ref_decode(input logic [31:0] pc, input logic [31:0] word,
                                    input logic err);
    dec_t       d;
    logic [5:0] op;
    logic [5:0] fn;
    op          = word[31:26];
    fn          = word[5:0];
    d           = '0;
    d.pc        = pc;
    d.fetch_err = err;
    d.rs        = word[25:21];
    d.rt        = word[20:16];
    d.imme      = word[15:0];
    if (op == OP_SPECIAL) begin
        if (fn inside {FN_ADDU, FN_SUBU, FN_OR, FN_SLL}) begin
            d.w_reg_ena = 1'b1;
            d.w_reg_dst = word[15:11];
        end else if (fn == FN_JR) begin
            d.is_branch = 1'b1;
        end else begin
            d.is_ri = 1'b1;
        end
    end else if (op inside {OP_ADDIU, OP_ORI, OP_LUI, OP_LW}) begin
        d.w_reg_ena = 1'b1;
        d.w_reg_dst = word[20:16];
        d.is_ls     = (op == OP_LW);
    end else if (op == OP_SW) begin
        d.is_ls = 1'b1;
    end else if (op inside {OP_BEQ, OP_BNE}) begin
        d.is_branch = 1'b1;
    end else if (op inside {OP_J, OP_JAL}) begin
        // the target covers the register fields, so jumps read no register.
        d.rs        = 5'd0;
        d.rt        = 5'd0;
        d.is_branch = 1'b1;
        d.w_reg_ena = (op == OP_JAL);
        d.w_reg_dst = (op == OP_JAL) ? REG_RA : 5'd0;
    end else begin
        d.is_ri = 1'b1;
    end
    if (d.is_ri) begin
        d.rs = 5'd0;
        d.rt = 5'd0;
    end
    return d;
endfunction

// the younger instruction may go with the older one only without a hazard.
function automatic logic ref_may_pair(input dec_t older, input dec_t younger);
    logic dep;
    dep = older.w_reg_ena && (older.w_reg_dst != 5'd0) &&
          ((older.w_reg_dst == younger.rs) || (older.w_reg_dst == younger.rt));
    return !dep && !(older.is_ls && younger.is_ls) && !older.is_branch;
endfunction

`endif

/* tests/tb_decode_issue.sv */
`timescale 1ns/1ps

module tb_decode_issue;
    import decode_pkg::*;

    `include "tb_decode_ref.svh"

    logic        clk = 1'b0;
    logic        reset_i, flush_i, fetch_valid_i, fetch_err_i, fetch_ready_o, exec_ready_i;
    logic [31:0] fetch_pc_i, fetch_inst_i;
    logic        iss0_valid_o, iss0_w_reg_ena_o, iss0_is_branch_o, iss0_is_ls_o;
    logic        iss0_is_ri_o, iss0_fetch_err_o;
    logic [31:0] iss0_pc_o;
    logic [4:0]  iss0_rs_o, iss0_rt_o, iss0_w_reg_dst_o;
    logic [15:0] iss0_imme_o;
    logic        iss1_valid_o, iss1_w_reg_ena_o, iss1_is_branch_o, iss1_is_ls_o;
    logic        iss1_is_ri_o, iss1_fetch_err_o;
    logic [31:0] iss1_pc_o;
    logic [4:0]  iss1_rs_o, iss1_rt_o, iss1_w_reg_dst_o;
    logic [15:0] iss1_imme_o;

    integer      seed = 22;
    int          sent = 0, issued = 0, cycles = 0, errors = 0, test_base = 0;
    dec_t        sb[$];
    logic        er_edge = 1'b0, rst_edge = 1'b1, bp_on = 1'b0;
    logic [31:0] next_pc = 32'h1000, last_pc = 32'h0, flush_floor = 32'h0;
    logic [31:0] dep_pc = 32'hffff_fffc;
    dec_t        prev0, prev1;
    logic        prev_v0, prev_v1;

    decode_issue_top i_decode_issue_top (.*);

    always #2 clk = ~clk;

    task automatic check(input string what, input logic [127:0] got, input logic [127:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Error: %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic report_fault(input string msg);
        errors++;
        $display("%0t ns: %s", $time, msg);
    endtask

    function automatic dec_t out_fields(input bit s);
        if (!s)
            return {iss0_pc_o, iss0_rs_o, iss0_rt_o, iss0_w_reg_ena_o, iss0_w_reg_dst_o,
                    iss0_imme_o, iss0_is_branch_o, iss0_is_ls_o, iss0_is_ri_o, iss0_fetch_err_o};
        return {iss1_pc_o, iss1_rs_o, iss1_rt_o, iss1_w_reg_ena_o, iss1_w_reg_dst_o,
                iss1_imme_o, iss1_is_branch_o, iss1_is_ls_o, iss1_is_ri_o, iss1_fetch_err_o};
    endfunction

    // handshakes and flushes are seen at the clock edge where they take effect.
    always @(posedge clk) begin
        cycles++;
        er_edge  = exec_ready_i;
        rst_edge = reset_i || flush_i;
        if (!reset_i && !fetch_ready_o && sb.size() < QUEUE_DEPTH)
            report_fault($sformatf("fetch_ready_o low with only %0d pending", sb.size()));
        if (rst_edge) begin
            if (flush_i)
                flush_floor = last_pc;
            sb.delete();
        end else if (fetch_valid_i && fetch_ready_o) begin
            sb.push_back(ref_decode(fetch_pc_i, fetch_inst_i, fetch_err_i));
            last_pc = fetch_pc_i;
        end
        if (cycles > 40 * sent + 200) begin
            $display("Timeout: no finish after %0d cycles, %0d pending", cycles, sb.size());
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic consume(input dec_t got, output dec_t exp);
        exp = got;
        issued++;
        if (got.pc <= flush_floor)
            report_fault($sformatf("pc %h from before the flush was issued", got.pc));
        if (sb.size() == 0)
            report_fault($sformatf("pc %h issued with nothing pending", got.pc));
        else begin
            exp = sb.pop_front();
            check($sformatf("issued pc %h", got.pc), got, exp);
        end
    endtask

    // outputs are stable at the falling edge, half a cycle after they change.
    always @(negedge clk) begin : monitor
        dec_t got0, got1, exp0, exp1;
        got0 = out_fields(1'b0);
        got1 = out_fields(1'b1);
        exp0 = got0;
        if (er_edge && !rst_edge) begin
            if (iss0_valid_o)
                consume(got0, exp0);
            if (iss1_valid_o) begin
                consume(got1, exp1);
                if (!ref_may_pair(exp0, exp1))
                    report_fault($sformatf("pair %h/%h breaks the pairing rule", got0.pc, got1.pc));
                if (got0.pc == dep_pc)
                    report_fault("dependent ADDU and ORI issued together");
            end
        end else if (!rst_edge) begin
            check("slot 0 while stalled", {iss0_valid_o, got0}, {prev_v0, prev0});
            check("slot 1 while stalled", {iss1_valid_o, got1}, {prev_v1, prev1});
        end
        prev0   = got0;
        prev1   = got1;
        prev_v0 = iss0_valid_o;
        prev_v1 = iss1_valid_o;
    end

    always @(negedge clk) begin
        if (bp_on && (($random(seed) & 7) == 0))
            exec_ready_i = !exec_ready_i;
    end

    task automatic make_supported(output logic [31:0] w);
        logic [31:0] r;
        int          k;
        r = $random(seed);
        k = $unsigned($random(seed)) % 14;
        // registers stay in r0..r7 so that hazards come up often.
        case (k)
            0: w = {OP_SPECIAL, 2'b0, r[2:0], 2'b0, r[5:3], 2'b0, r[8:6], r[13:9], FN_ADDU};
            1: w = {OP_SPECIAL, 2'b0, r[2:0], 2'b0, r[5:3], 2'b0, r[8:6], r[13:9], FN_SUBU};
            2: w = {OP_SPECIAL, 2'b0, r[2:0], 2'b0, r[5:3], 2'b0, r[8:6], r[13:9], FN_OR};
            3: w = {OP_SPECIAL, 2'b0, r[2:0], 2'b0, r[5:3], 2'b0, r[8:6], r[13:9], FN_SLL};
            4: w = {OP_SPECIAL, 2'b0, r[2:0], 2'b0, r[5:3], 2'b0, r[8:6], r[13:9], FN_JR};
            5: w = {OP_ADDIU, 2'b0, r[2:0], 2'b0, r[5:3], r[31:16]};
            6: w = {OP_ORI, 2'b0, r[2:0], 2'b0, r[5:3], r[31:16]};
            7: w = {OP_LUI, 2'b0, r[2:0], 2'b0, r[5:3], r[31:16]};
            8: w = {OP_LW, 2'b0, r[2:0], 2'b0, r[5:3], r[31:16]};
            9: w = {OP_SW, 2'b0, r[2:0], 2'b0, r[5:3], r[31:16]};
            10: w = {OP_BEQ, 2'b0, r[2:0], 2'b0, r[5:3], r[31:16]};
            11: w = {OP_BNE, 2'b0, r[2:0], 2'b0, r[5:3], r[31:16]};
            12: w = {OP_J, r[25:0]};
            default: w = {OP_JAL, r[25:0]};
        endcase
    endtask

    task automatic make_reserved(output logic [31:0] w);
        dec_t d;
        do begin
            w = $random(seed);
            d = ref_decode(32'h0, w, 1'b0);
        end while (!d.is_ri);
    endtask

    task automatic send(input logic [31:0] word, input logic err);
        @(negedge clk);
        fetch_valid_i = 1'b1;
        fetch_pc_i    = next_pc;
        fetch_inst_i  = word;
        fetch_err_i   = err;
        sent++;
        next_pc += 4;
        @(posedge clk);
        while (!fetch_ready_o)
            @(posedge clk);
    endtask

    task automatic stop_fetch;
        @(negedge clk);
        fetch_valid_i = 1'b0;
    endtask

    task automatic run_stream(input int n, input bit mix);
        logic [31:0] w;
        logic        err;
        for (int k = 0; k < n; k++) begin
            err = 1'b0;
            if (mix && ($random(seed) & 1))
                make_reserved(w);
            else begin
                make_supported(w);
                err = mix && (($random(seed) & 3) == 0);
            end
            send(w, err);
            if (($random(seed) & 7) == 0)
                stop_fetch();
        end
        stop_fetch();
    endtask

    task automatic drain;
        do
            @(posedge clk);
        while (sb.size() != 0);
        repeat (8) @(posedge clk);
    endtask

    task automatic check_idle(input string when);
        check({when, ": fetch_ready_o"}, fetch_ready_o, 1'b1);
        check({when, ": issue valids"}, {iss0_valid_o, iss1_valid_o}, 2'b00);
    endtask

    task automatic end_test(input string name);
        $display("test %s done: %0d errors", name, errors - test_base);
        test_base = errors;
    endtask

    initial begin
        reset_i       = 1'b1;
        flush_i       = 1'b0;
        fetch_valid_i = 1'b0;
        fetch_pc_i    = 32'h0;
        fetch_inst_i  = 32'h0;
        fetch_err_i   = 1'b0;
        exec_ready_i  = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        check_idle("after reset");

        run_stream(200, 1'b0);
        drain();
        end_test("in-order stream");

        // both instructions wait in the queue so that they reach the lanes as one pair.
        @(negedge clk);
        exec_ready_i = 1'b0;
        dep_pc       = next_pc;
        send({OP_SPECIAL, 5'd1, 5'd2, 5'd5, 5'd0, FN_ADDU}, 1'b0);
        send({OP_ORI, 5'd5, 5'd6, 16'h00ff}, 1'b0);
        stop_fetch();
        @(negedge clk);
        exec_ready_i = 1'b1;
        run_stream(40, 1'b0);
        drain();
        end_test("pairing rule");

        run_stream(60, 1'b1);
        drain();
        end_test("reserved and fetch error");

        bp_on = 1'b1;
        run_stream(200, 1'b0);
        drain();
        end_test("back-pressure");

        run_stream(30, 1'b0);
        @(negedge clk);
        flush_i = 1'b1;
        @(negedge clk);
        flush_i = 1'b0;
        check_idle("after flush");
        run_stream(30, 1'b0);
        drain();
        bp_on = 1'b0;
        end_test("flush");

        $display("summary: 5 tests, %0d sent, %0d issued, %0d errors", sent, issued, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

/* build.f */
+incdir+tests
src/decode_pkg.sv
src/fetch_slot_if.sv
src/id_bus_if.sv
src/fetch_queue.sv
src/id_stage_reg.sv
src/decode_lane.sv
src/issue_pair.sv
src/decode_issue_top.sv
tests/tb_decode_issue.sv

/* Bender.yml */
package:
  name: decode_issue

sources:
  - files:
      - src/decode_pkg.sv
      - src/fetch_slot_if.sv
      - src/id_bus_if.sv
      - src/fetch_queue.sv
      - src/id_stage_reg.sv
      - src/decode_lane.sv
      - src/issue_pair.sv
      - src/decode_issue_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_decode_issue.sv
